//--- hw/enc_types_pkg.sv
// -----------------------------------------------
// encoder value types: preload/position, count
// reading with overflow msb, period reading, and
// the midrange reset value
// -----------------------------------------------

package enc_types_pkg;

    // position width, shared by preload register and counter
    typedef logic [23:0] enc_preload_t;

    // position reading: {ovf, count[23:0]}
    typedef logic [24:0] enc_count_t;

    // period reading
    // bit 31   direction of the latest step, 1 = forward
    // bits 30:0 clock cycles between the last two edges
    typedef logic [31:0] enc_period_t;

    // midpoint of the 24-bit range, used as reset preload and count
    localparam enc_preload_t ENC_MIDRANGE = 24'h800000;

endpackage

//--- hw/enc_regmap_pkg.sv
// -----------------------------------------------
// register map of the encoder block: address and
// data types, block code and register offsets
// -----------------------------------------------

package enc_regmap_pkg;

    // -----------------------------------------------
    // address layout
    // -----------------------------------------------
    // [15:12] block code
    // [11:8]  unused by this block
    // [7:4]   channel, 1 to NUM_ENC
    // [3:0]   register offset
    typedef logic [15:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;   // bus data word
    typedef logic [3:0]  blk_code_t;   // block field

    // block that owns the encoder registers
    localparam blk_code_t ADDR_MAIN = 4'h0;

    // -----------------------------------------------
    // per-channel register offsets
    // -----------------------------------------------
    localparam logic [3:0] OFF_ENC_LOAD  = 4'h4;   // preload, r/w
    localparam logic [3:0] OFF_ENC_DATA  = 4'h5;   // position + ovf, ro
    localparam logic [3:0] OFF_PER_DATA  = 4'h6;   // period + dir, ro
    localparam logic [3:0] OFF_FREQ_DATA = 4'h7;   // freq count, reads zero

endpackage

//--- hw/enc_debounce.sv
// -----------------------------------------------
// glitch filter for one raw encoder line
// -----------------------------------------------
`timescale 1ns/1ns

module enc_debounce #(
    parameter int DEBOUNCE_LEN = 4        // stable cycles before accept
) (
    input  logic sysclk,
    input  logic arst_n,
    input  logic raw,                     // raw line from the connector
    output logic filt                     // filtered level
);

    localparam int CW = $clog2(DEBOUNCE_LEN + 1);

    logic          sync1;                 // metastability stage
    logic          sync2;                 // synchronized level
    logic [CW-1:0] stable_cnt;            // cycles sync2 has differed from filt

    always_ff @(posedge sysclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sync1      <= 1'b0;
            sync2      <= 1'b0;
            stable_cnt <= '0;
            filt       <= 1'b0;
        end
        else
        begin
            sync1 <= raw;
            sync2 <= sync1;
            if (sync2 == filt)
                stable_cnt <= '0;         // back to old level, drop the glitch
            else if (stable_cnt == CW'(DEBOUNCE_LEN))
            begin
                filt       <= sync2;      // held long enough, accept it
                stable_cnt <= '0;
            end
            else
                stable_cnt <= stable_cnt + 1'b1;
        end
    end

endmodule

//--- hw/enc_quad_counter.sv
// -----------------------------------------------
// x4 quadrature decoder with preloadable position
// count, sticky overflow flag and step direction
// -----------------------------------------------
`timescale 1ns/1ns

module enc_quad_counter
    import enc_types_pkg::*;
(
    input  logic         sysclk,
    input  logic         arst_n,
    input  logic         enc_a,           // filtered a line
    input  logic         enc_b,           // filtered b line
    input  logic         set_enc,         // one-cycle preload strobe
    input  enc_preload_t preload,
    output enc_count_t   quad_data,       // {ovf, count}
    output logic         dir              // 1 = forward
);

    logic         a_prev;                 // levels seen at the last edge
    logic         b_prev;
    logic         step_en;                // exactly one line changed
    logic         step_fwd;               // that change was a forward step
    enc_preload_t count;
    logic         ovf;                    // sticky, cleared by preload

    // forward sequence in a,b is 00 -> 01 -> 11 -> 10 -> 00
    // a change on both lines at once has even parity and is dropped
    assign step_en  = (enc_a ^ a_prev) ^ (enc_b ^ b_prev);
    assign step_fwd = enc_b ^ a_prev;     // new b differs from old a on forward

    always_ff @(posedge sysclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            a_prev <= 1'b0;
            b_prev <= 1'b0;
            count  <= ENC_MIDRANGE;
            ovf    <= 1'b0;
            dir    <= 1'b0;
        end
        else
        begin
            a_prev <= enc_a;
            b_prev <= enc_b;
            if (step_en)
                dir <= step_fwd;          // follows motion even during preload

            if (set_enc)
            begin
                count <= preload;         // preload beats a same-cycle step
                ovf   <= 1'b0;
            end
            else if (step_en)
            begin
                if (step_fwd)
                begin
                    if (&count)
                        ovf <= 1'b1;      // wraps to zero
                    count <= count + 1'b1;
                end
                else
                begin
                    if (count == '0)
                        ovf <= 1'b1;      // wraps to all ones
                    count <= count - 1'b1;
                end
            end
        end
    end

    assign quad_data = {ovf, count};

endmodule

//--- hw/enc_period_meter.sv
// -----------------------------------------------
// period measurement between quadrature edges,
// tagged with the direction of motion
// -----------------------------------------------
`timescale 1ns/1ns

module enc_period_meter
    import enc_types_pkg::*;
(
    input  logic        sysclk,
    input  logic        arst_n,
    input  logic        enc_a,            // filtered a line
    input  logic        enc_b,            // filtered b line
    input  logic        dir,              // from the quadrature counter
    output enc_period_t perd_data         // {dir, cycles}
);

    localparam int CNT_W = $bits(enc_period_t) - 1;

    logic             a_dly;              // own delayed copies for edge detect
    logic             b_dly;
    logic             edge_det;           // edge on either line this cycle
    logic             edge_q;             // same, one cycle later
    logic [CNT_W-1:0] cycle_cnt;          // cycles since the last edge

    assign edge_det = (enc_a ^ a_dly) | (enc_b ^ b_dly);

    // latch runs one cycle after the edge, when the counter has
    // already updated dir for that step; spacing stays the same
    always_ff @(posedge sysclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            a_dly     <= 1'b0;
            b_dly     <= 1'b0;
            edge_q    <= 1'b0;
            cycle_cnt <= '0;
            perd_data <= '0;
        end
        else
        begin
            a_dly  <= enc_a;
            b_dly  <= enc_b;
            edge_q <= edge_det;
            if (edge_q)
            begin
                perd_data <= {dir, cycle_cnt};
                cycle_cnt <= CNT_W'(1);   // restart, this cycle counts as one
            end
            else if (!(&cycle_cnt))
                cycle_cnt <= cycle_cnt + 1'b1;
            // else hold at max, encoder has stopped
        end
    end

endmodule

//--- hw/ctrl_enc.sv
// -----------------------------------------------
// encoder block top: per-channel filter, counter
// and period instances, preload registers, write
// strobes and register read multiplexer
// -----------------------------------------------
`timescale 1ns/1ns

module ctrl_enc
    import enc_types_pkg::*;
    import enc_regmap_pkg::*;
#(
    parameter int NUM_ENC      = 4,       // channels, 1 to 15
    parameter int DEBOUNCE_LEN = 4        // filter length, cycles
) (
    input  logic             sysclk,
    input  logic             arst_n,
    input  logic [1:NUM_ENC] enc_a,       // raw quadrature lines, bit = channel
    input  logic [1:NUM_ENC] enc_b,
    input  reg_addr_t        reg_raddr,   // combinational read
    output reg_data_t        reg_rdata,
    input  reg_addr_t        reg_waddr,   // strobed write
    input  reg_data_t        reg_wdata,
    input  logic             reg_wen
);

    localparam logic [3:0] MAX_CH = 4'(NUM_ENC);

    // -----------------------------------------------
    // per-channel signals
    // -----------------------------------------------
    logic [1:NUM_ENC] enc_a_filt;         // filtered lines
    logic [1:NUM_ENC] enc_b_filt;
    logic [1:NUM_ENC] set_enc;            // preload strobe, one cycle
    logic [1:NUM_ENC] dir;                // latest step direction
    enc_preload_t     preload   [1:NUM_ENC];
    enc_count_t       quad_data [1:NUM_ENC];
    enc_period_t      perd_data [1:NUM_ENC];

    // write address fields
    blk_code_t  wr_blk;
    logic [3:0] wr_ch;
    logic [3:0] wr_off;
    logic       wr_load;                  // valid preload write, any channel

    // read address fields
    logic [3:0] rd_ch;
    logic [3:0] rd_off;

    assign wr_blk  = reg_waddr[15:12];
    assign wr_ch   = reg_waddr[7:4];
    assign wr_off  = reg_waddr[3:0];
    assign wr_load = reg_wen && (wr_blk == ADDR_MAIN) && (wr_off == OFF_ENC_LOAD)
                     && (wr_ch >= 4'd1) && (wr_ch <= MAX_CH);

    // -----------------------------------------------
    // channels
    // -----------------------------------------------
    for (genvar i = 1; i <= NUM_ENC; i++)
    begin : g_ch
        localparam logic [3:0] CH = 4'(i);

        enc_debounce #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) u_filt_a (
            .sysclk (sysclk),
            .arst_n (arst_n),
            .raw    (enc_a[i]),
            .filt   (enc_a_filt[i])
        );

        enc_debounce #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) u_filt_b (
            .sysclk (sysclk),
            .arst_n (arst_n),
            .raw    (enc_b[i]),
            .filt   (enc_b_filt[i])
        );

        enc_quad_counter u_quad (
            .sysclk    (sysclk),
            .arst_n    (arst_n),
            .enc_a     (enc_a_filt[i]),
            .enc_b     (enc_b_filt[i]),
            .set_enc   (set_enc[i]),
            .preload   (preload[i]),
            .quad_data (quad_data[i]),
            .dir       (dir[i])
        );

        enc_period_meter u_perd (
            .sysclk    (sysclk),
            .arst_n    (arst_n),
            .enc_a     (enc_a_filt[i]),
            .enc_b     (enc_b_filt[i]),
            .dir       (dir[i]),
            .perd_data (perd_data[i])
        );

        // preload register and its strobe; counter loads one edge later
        always_ff @(posedge sysclk or negedge arst_n)
        begin
            if (!arst_n)
            begin
                preload[i] <= ENC_MIDRANGE;
                set_enc[i] <= 1'b0;
            end
            else
            begin
                set_enc[i] <= wr_load && (wr_ch == CH);
                if (wr_load && (wr_ch == CH))
                    preload[i] <= reg_wdata[23:0];
            end
        end
    end

    // -----------------------------------------------
    // read mux, block field ignored
    // -----------------------------------------------
    assign rd_ch  = reg_raddr[7:4];
    assign rd_off = reg_raddr[3:0];

    always_comb
    begin
        reg_rdata = '0;                   // bad channel or offset reads zero
        if ((rd_ch >= 4'd1) && (rd_ch <= MAX_CH))
        begin
            case (rd_off)
                OFF_ENC_LOAD:  reg_rdata = reg_data_t'(preload[rd_ch]);
                OFF_ENC_DATA:  reg_rdata = reg_data_t'(quad_data[rd_ch]);
                OFF_PER_DATA:  reg_rdata = perd_data[rd_ch];
                OFF_FREQ_DATA: reg_rdata = '0;   // no frequency counter
                default:       reg_rdata = '0;
            endcase
        end
    end

endmodule

//--- dv/tb_ctrl_enc.sv
// -----------------------------------------------
// testbench for the encoder block: clock, reset,
// quadrature stimulus, reference model, register
// checks and watchdog
// -----------------------------------------------
`timescale 1ns/1ns

module tb_ctrl_enc
    import enc_types_pkg::*;
    import enc_regmap_pkg::*;
();

    localparam int NUM_ENC      = 4;
    localparam int DEBOUNCE_LEN = 4;
    localparam int CLK_NS       = 8;
    localparam int SETTLE       = DEBOUNCE_LEN + 8;   // cycles after the last input change
    localparam int GAP_MIN      = DEBOUNCE_LEN + 6;   // step spacing, well above the filter
    localparam int GAP_SPAN     = 16;
    localparam int RUNS         = 6;
    localparam int RUN_STEPS    = 8;
    localparam int CHECK_CYC    = 16 * 16 + 2;      // one full address sweep
    localparam int NUM_CHECKS   = 14;
    // sweeps + counting runs + period bursts + writes and glitches, plus margin
    localparam int WATCHDOG_CYC = NUM_CHECKS * (CHECK_CYC + SETTLE)
                                  + RUNS * RUN_STEPS * (GAP_MIN + GAP_SPAN)
                                  + NUM_ENC * 3 * (GAP_MIN + GAP_SPAN) + 2000;

    logic             sysclk;
    logic             arst_n;
    logic [1:NUM_ENC] enc_a;
    logic [1:NUM_ENC] enc_b;
    reg_addr_t        reg_raddr;
    reg_data_t        reg_rdata;
    reg_addr_t        reg_waddr;
    reg_data_t        reg_wdata;
    logic             reg_wen;

    // -----------------------------------------------
    // reference model state, per channel
    // -----------------------------------------------
    enc_preload_t m_preload   [1:NUM_ENC];
    enc_preload_t m_pos       [1:NUM_ENC];
    logic         m_ovf       [1:NUM_ENC];
    enc_period_t  m_period    [1:NUM_ENC];
    logic         m_per_known [1:NUM_ENC];  // first step after reset has no reference
    logic         m_stepped   [1:NUM_ENC];
    longint       m_last_t    [1:NUM_ENC];  // drive time of the previous step

    integer seed;
    int     err_cnt = 0;
    logic   chk_valid;                      // reg_raddr holds an address to compare

    ctrl_enc #(
        .NUM_ENC      (NUM_ENC),
        .DEBOUNCE_LEN (DEBOUNCE_LEN)
    ) dut0 (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .enc_a     (enc_a),
        .enc_b     (enc_b),
        .reg_raddr (reg_raddr),
        .reg_rdata (reg_rdata),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_wen   (reg_wen)
    );

    initial
    begin
        sysclk = 1'b0;
        forever #(CLK_NS / 2) sysclk = ~sysclk;
    end

    // expected read data for any address
    function automatic reg_data_t ref_rdata(input reg_addr_t addr);
        int ch;
        ch = int'(addr[7:4]);
        ref_rdata = '0;                     // block field plays no part on reads
        if (ch >= 1 && ch <= NUM_ENC)
        begin
            case (addr[3:0])
                OFF_ENC_LOAD: ref_rdata = {8'h00, m_preload[ch]};
                OFF_ENC_DATA: ref_rdata = {7'h00, m_ovf[ch], m_pos[ch]};
                OFF_PER_DATA: ref_rdata = m_period[ch];
                default:      ref_rdata = '0;   // freq and unknown offsets
            endcase
        end
    endfunction

    function automatic logic checkable(input reg_addr_t addr);
        int ch;
        ch = int'(addr[7:4]);
        checkable = 1'b1;
        if (addr[3:0] == OFF_PER_DATA && ch >= 1 && ch <= NUM_ENC)
            checkable = m_per_known[ch];
    endfunction

    function automatic int pick(input int lo, input int span);
        pick = lo + int'({$random(seed)} % 32'(span));
    endfunction

    function automatic reg_addr_t enc_addr(input blk_code_t blk, input int ch,
                                           input logic [3:0] off);
        enc_addr = {blk, 4'h0, 4'(ch), off};
    endfunction

    // -----------------------------------------------
    // compare process, one read per cycle
    // -----------------------------------------------
    always @(posedge sysclk)
    begin
        if (chk_valid)
        begin
            assert (reg_rdata === ref_rdata(reg_raddr))
            else
            begin
                err_cnt = err_cnt + 1;
                $display("** Error reg_rdata addr=%h expected=%h actual=%h",
                         reg_raddr, ref_rdata(reg_raddr), reg_rdata);
                $display("** FAIL **");
                $fatal(1, "register read returned a wrong value");
            end
        end
    end

    task automatic settle();
        repeat (SETTLE) @(posedge sysclk);
    endtask

    // sweep every channel and offset, random block field
    task automatic check_all();
        reg_addr_t addr;
        for (int ch = 0; ch < 16; ch++)
            for (int off = 0; off < 16; off++)
            begin
                addr = enc_addr(4'($random(seed)), ch, 4'(off));
                @(posedge sysclk);
                reg_raddr <= addr;
                chk_valid <= checkable(addr);
            end
        @(posedge sysclk);
        chk_valid <= 1'b0;                  // last address still compared at this edge
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data, input logic wen);
        int ch;
        ch = int'(addr[7:4]);
        @(posedge sysclk);
        reg_waddr <= addr;
        reg_wdata <= data;
        reg_wen   <= wen;
        @(posedge sysclk);
        reg_wen <= 1'b0;
        if (wen && addr[15:12] == ADDR_MAIN && addr[3:0] == OFF_ENC_LOAD
            && ch >= 1 && ch <= NUM_ENC)
        begin
            m_preload[ch] = data[23:0];
            m_pos[ch]     = data[23:0];
            m_ovf[ch]     = 1'b0;           // preload clears the flag
        end
    endtask

    // one quadrature step, then hold for the rest of gap
    task automatic step_hold(input int ch, input logic fwd, input int gap);
        longint now;
        @(posedge sysclk);
        now = $time;
        // forward order 00,01,11,10: equal lines move b, unequal move a
        if (fwd == (enc_a[ch] == enc_b[ch]))
            enc_b[ch] <= !enc_b[ch];
        else
            enc_a[ch] <= !enc_a[ch];
        if (fwd)
        begin
            if (&m_pos[ch])
                m_ovf[ch] = 1'b1;
            m_pos[ch] = m_pos[ch] + 24'd1;
        end
        else
        begin
            if (m_pos[ch] == '0)
                m_ovf[ch] = 1'b1;
            m_pos[ch] = m_pos[ch] - 24'd1;
        end
        m_period[ch]    = {fwd, 31'((now - m_last_t[ch]) / CLK_NS)};
        m_per_known[ch] = m_stepped[ch];
        m_stepped[ch]   = 1'b1;
        m_last_t[ch]    = now;
        repeat (gap - 1) @(posedge sysclk);
    endtask

    // short pulse on one line, below the filter length
    task automatic glitch(input int ch, input logic on_a, input int width);
        @(posedge sysclk);
        if (on_a)
            enc_a[ch] <= !enc_a[ch];
        else
            enc_b[ch] <= !enc_b[ch];
        repeat (width) @(posedge sysclk);
        if (on_a)
            enc_a[ch] <= !enc_a[ch];
        else
            enc_b[ch] <= !enc_b[ch];
        repeat (DEBOUNCE_LEN + 4) @(posedge sysclk);
    endtask

    // -----------------------------------------------
    // test sequence
    // -----------------------------------------------
    initial
    begin
        int   ch;
        int   gap;
        logic fwd;
        seed      = 32'h3a76;
        arst_n    = 1'b0;
        enc_a     = '0;
        enc_b     = '0;
        reg_raddr = '0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_wen   = 1'b0;
        chk_valid = 1'b0;
        for (int i = 1; i <= NUM_ENC; i++)
        begin
            m_preload[i]   = ENC_MIDRANGE;
            m_pos[i]       = ENC_MIDRANGE;
            m_ovf[i]       = 1'b0;
            m_period[i]    = '0;
            m_per_known[i] = 1'b1;          // zero until the first edge
            m_stepped[i]   = 1'b0;
            m_last_t[i]    = 0;
        end
        repeat (10) @(posedge sysclk);
        arst_n <= 1'b1;
        settle();
        check_all();                        // reset state

        for (int i = 1; i <= NUM_ENC; i++)
            write_reg(enc_addr(ADDR_MAIN, i, OFF_ENC_LOAD), reg_data_t'($random(seed)), 1'b1);
        settle();
        check_all();
        for (int i = 1; i <= NUM_ENC; i++)
        begin
            write_reg(enc_addr(ADDR_MAIN ^ 4'h1, i, OFF_ENC_LOAD), 32'h0012_3456, 1'b1);
            write_reg(enc_addr(ADDR_MAIN, i, OFF_ENC_DATA), 32'h0065_4321, 1'b1);
            write_reg(enc_addr(ADDR_MAIN, i, OFF_ENC_LOAD), 32'h00ab_cdef, 1'b0);
        end
        settle();
        check_all();                        // ignored writes

        repeat (RUNS)
        begin
            ch  = pick(1, NUM_ENC);
            fwd = 1'($random(seed));
            gap = pick(GAP_MIN, GAP_SPAN);
            repeat (pick(1, RUN_STEPS)) step_hold(ch, fwd, gap);
            settle();
            check_all();
        end

        ch = pick(1, NUM_ENC);              // overflow on one channel
        write_reg(enc_addr(ADDR_MAIN, ch, OFF_ENC_LOAD), 32'h00ff_ffff, 1'b1);
        settle();
        step_hold(ch, 1'b1, GAP_MIN);
        settle();
        check_all();
        write_reg(enc_addr(ADDR_MAIN, ch, OFF_ENC_LOAD), reg_data_t'($random(seed)), 1'b1);
        settle();
        check_all();

        for (int i = 1; i <= NUM_ENC; i++)  // fixed spacing per channel
        begin
            gap = pick(GAP_MIN, GAP_SPAN);
            fwd = 1'($random(seed));
            repeat (3) step_hold(i, fwd, gap);
        end
        settle();
        check_all();

        repeat (8) glitch(pick(1, NUM_ENC), 1'($random(seed)), pick(1, DEBOUNCE_LEN - 1));
        settle();
        check_all();

        if (err_cnt == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // watchdog
    initial
    begin
        #(WATCHDOG_CYC * CLK_NS);
        $display("** FAIL **");
        $fatal(1, "watchdog expired, the tests did not finish in time");
    end

endmodule

//--- build.f
hw/enc_types_pkg.sv
hw/enc_regmap_pkg.sv
hw/enc_debounce.sv
hw/enc_quad_counter.sv
hw/enc_period_meter.sv
hw/ctrl_enc.sv
dv/tb_ctrl_enc.sv

//--- Makefile
# Verilator simulation of the encoder block testbench

TOP := tb_ctrl_enc

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module $(TOP) -f build.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '** PASS **' > /dev/null

clean:
	rm -rf obj_dir
